// ==== include/mdu_defs.svh ====
// Width and size macros shared by the multiply-divide pipeline; include where a width is needed
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// ------------------------------------------------------------
// Datapath
// ------------------------------------------------------------

`define MDU_XLEN            32

// ------------------------------------------------------------
// Identity carried to writeback
// ------------------------------------------------------------

`define MDU_PR_BITS         7
`define MDU_ROB_BITS        7

// Iterative divider, counter must reach MDU_DIV_STEPS
`define MDU_DIV_STEPS       32
`define MDU_DIV_CNT_BITS    6

`endif

// ==== design/mdu_pkg.sv ====
// Operation encoding and the issue and writeback bundles, imported by every pipeline module
`default_nettype none

package mdu_pkg;

    `include "mdu_defs.svh"

    // Multiply view, mul_kind is MUL/MULH/MULHSU/MULHU
    typedef struct packed {
        logic       is_div;
        logic [1:0] mul_kind;
    } mdu_mul_op_t;

    // Divide view
    typedef struct packed {
        logic is_div;
        logic is_rem;
        logic is_unsigned;
    } mdu_div_op_t;

    // One 3-bit word, decoded by is_div
    typedef union packed {
        logic [2:0]  raw;
        mdu_mul_op_t mul;
        mdu_div_op_t div;
    } mdu_op_u;

    typedef struct packed {
        logic [`MDU_PR_BITS-1:0]  dest_pr;
        logic [`MDU_ROB_BITS-1:0] rob_index;
    } mdu_tag_t;

    typedef struct packed {
        mdu_op_u              op;
        logic [`MDU_XLEN-1:0] a;
        logic [`MDU_XLEN-1:0] b;
        mdu_tag_t             tag;
    } mdu_issue_t;

    typedef struct packed {
        logic [`MDU_XLEN-1:0] data;
        mdu_tag_t             tag;
    } mdu_wb_t;

endpackage

`default_nettype wire

// ==== design/div32_iterative.sv ====
// Shift-subtract divider for signed and unsigned RISC-V division, one quotient bit per cycle
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module div32_iterative (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 start,
    input  logic                 is_signed,
    input  logic [`MDU_XLEN-1:0] a,
    input  logic [`MDU_XLEN-1:0] b,
    output logic                 done,
    output logic [`MDU_XLEN-1:0] quotient,
    output logic [`MDU_XLEN-1:0] remainder
);

    logic                         busy;
    logic [`MDU_DIV_CNT_BITS-1:0] step_cnt;
    logic                         last_step;
    logic [`MDU_XLEN-1:0]         a_mag;
    logic [`MDU_XLEN-1:0]         b_mag;
    logic [`MDU_XLEN-1:0]         div_mag;
    logic [`MDU_XLEN-1:0]         quo_r;
    logic [`MDU_XLEN-1:0]         rem_r;
    logic [`MDU_XLEN:0]           shifted;
    logic [`MDU_XLEN:0]           diff;
    logic                         neg_quo;
    logic                         neg_rem;
    logic                         div_zero;

    // Magnitudes of the operands
    assign a_mag = (is_signed & a[`MDU_XLEN-1]) ? -a : a;
    assign b_mag = (is_signed & b[`MDU_XLEN-1]) ? -b : b;

    // One restoring step, diff MSB set means the divisor did not fit
    assign shifted   = {rem_r, quo_r[`MDU_XLEN-1]};
    assign diff      = shifted - {1'b0, div_mag};
    assign last_step = (step_cnt == `MDU_DIV_CNT_BITS'(`MDU_DIV_STEPS));

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            done     <= 1'b0;
            step_cnt <= '0;
        end else if (busy) begin
            if (last_step) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (start) begin
            quo_r    <= a_mag;
            rem_r    <= '0;
            div_mag  <= b_mag;
            neg_quo  <= is_signed & (a[`MDU_XLEN-1] ^ b[`MDU_XLEN-1]);
            neg_rem  <= is_signed & a[`MDU_XLEN-1];
            div_zero <= (b == '0);
        end else if (busy && !last_step) begin
            if (!diff[`MDU_XLEN]) begin
                rem_r <= diff[`MDU_XLEN-1:0];
                quo_r <= {quo_r[`MDU_XLEN-2:0], 1'b1};
            end else begin
                rem_r <= shifted[`MDU_XLEN-1:0];
                quo_r <= {quo_r[`MDU_XLEN-2:0], 1'b0};
            end
        end else if (busy) begin
            // Divide by zero leaves rem_r = |a|, so only the quotient is forced.
            // Overflow (most negative / -1) comes out right with no special case
            quotient  <= div_zero ? '1 : (neg_quo ? -quo_r : quo_r);
            remainder <= neg_rem ? -rem_r : rem_r;
        end
    end

endmodule

`default_nettype wire

// ==== design/mdu_ex_stage.sv ====
// EX stage register of the pipeline, holds one operation and detects reuse of the divider result
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_ex_stage
    import mdu_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 issue_valid,
    input  mdu_issue_t           issue,
    output logic                 issue_ready,
    input  logic                 mul_stall,
    input  logic                 div_stall,
    output logic                 ex_valid,
    output mdu_op_u              ex_op,
    output logic [`MDU_XLEN-1:0] ex_a,
    output logic [`MDU_XLEN-1:0] ex_b,
    output mdu_tag_t             ex_tag,
    output logic                 ex_advance,
    output logic                 ex_hit,
    input  logic                 dw_valid,
    input  mdu_op_u              dw_op,
    input  logic [`MDU_XLEN-1:0] dw_a,
    input  logic [`MDU_XLEN-1:0] dw_b
);

    logic ex_hold;

    // ------------------------------------------------------------
    // Stall control
    // ------------------------------------------------------------

    // Only the path this operation goes to can hold EX
    assign ex_hold     = ex_valid & (ex_op.div.is_div ? div_stall : mul_stall);
    assign ex_advance  = ex_valid & ~ex_hold;
    assign issue_ready = ~ex_hold;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
        end else if (!ex_hold) begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!ex_hold) begin
            ex_op  <= issue.op;
            ex_a   <= issue.a;
            ex_b   <= issue.b;
            ex_tag <= issue.tag;
        end
    end

    // ------------------------------------------------------------
    // Divider result reuse
    // ------------------------------------------------------------

    // Same signedness and operands as DIV_WB, so the divider already has the answer
    assign ex_hit = ex_valid & ex_op.div.is_div
                  & dw_valid & dw_op.div.is_div
                  & (ex_op.div.is_unsigned == dw_op.div.is_unsigned)
                  & (ex_a == dw_a)
                  & (ex_b == dw_b);

endmodule

`default_nettype wire

// ==== design/mdu_mul_path.sv ====
// Multiply result path, registers a 33x33 signed product into MUL_WB and picks the result word
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_mul_path
    import mdu_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ex_valid,
    input  mdu_op_u              ex_op,
    input  logic [`MDU_XLEN-1:0] ex_a,
    input  logic [`MDU_XLEN-1:0] ex_b,
    input  mdu_tag_t             ex_tag,
    input  logic                 ex_advance,
    input  logic                 mul_grant,
    output logic                 mul_stall,
    output logic                 mul_req,
    output mdu_wb_t              mul_wb
);

    logic                          mul_load;
    logic signed [`MDU_XLEN:0]     a_ext;
    logic signed [`MDU_XLEN:0]     b_ext;
    logic [2*`MDU_XLEN-1:0]        product;
    logic                          mw_valid;
    logic [1:0]                    mw_kind;
    mdu_tag_t                      mw_tag;

    assign mul_load = ex_valid & ex_advance & ~ex_op.mul.is_div;

    // Sign bits: MUL/MULH both, MULHSU a only, MULHU neither
    assign a_ext = {(ex_op.mul.mul_kind != 2'd3) & ex_a[`MDU_XLEN-1], ex_a};
    assign b_ext = {~ex_op.mul.mul_kind[1] & ex_b[`MDU_XLEN-1], ex_b};

    // ------------------------------------------------------------
    // MUL_WB stage
    // ------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mw_valid <= 1'b0;
        end else if (mul_load) begin
            mw_valid <= 1'b1;
        end else if (mul_grant) begin
            mw_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (mul_load) begin
            product <= a_ext * b_ext;
            mw_kind <= ex_op.mul.mul_kind;
            mw_tag  <= ex_tag;
        end
    end

    assign mul_stall = mw_valid & ~mul_grant;
    assign mul_req   = mw_valid;

    // Low word for MUL, high word for the MULH variants
    assign mul_wb.data = (mw_kind == 2'd0) ? product[`MDU_XLEN-1:0]
                                           : product[2*`MDU_XLEN-1:`MDU_XLEN];
    assign mul_wb.tag  = mw_tag;

endmodule

`default_nettype wire

// ==== design/mdu_div_path.sv ====
// Divide result path, DIV_WB register with reuse data and control of the iterative divider
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_div_path
    import mdu_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ex_valid,
    input  mdu_op_u              ex_op,
    input  logic [`MDU_XLEN-1:0] ex_a,
    input  logic [`MDU_XLEN-1:0] ex_b,
    input  mdu_tag_t             ex_tag,
    input  logic                 ex_advance,
    input  logic                 ex_hit,
    input  logic                 div_grant,
    output logic                 div_stall,
    output logic                 div_req,
    output mdu_wb_t              div_wb,
    output logic                 dw_valid,
    output mdu_op_u              dw_op,
    output logic [`MDU_XLEN-1:0] dw_a,
    output logic [`MDU_XLEN-1:0] dw_b
);

    logic                 div_load;
    logic                 div_start;
    logic                 div_done;
    logic [`MDU_XLEN-1:0] quotient;
    logic [`MDU_XLEN-1:0] remainder;
    logic                 dw_hit;
    logic [`MDU_XLEN-1:0] dw_hit_data;
    mdu_tag_t             dw_tag;

    assign div_load  = ex_valid & ex_advance & ex_op.div.is_div;
    // A hit reuses the held result, so the divider keeps it
    assign div_start = div_load & ~ex_hit;

    // ------------------------------------------------------------
    // DIV_WB stage
    // ------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            dw_valid <= 1'b0;
            dw_hit   <= 1'b0;
        end else if (div_load) begin
            dw_valid <= 1'b1;
            dw_hit   <= ex_hit;
        end else if (div_grant) begin
            dw_valid <= 1'b0;
        end
    end

    // Finished result picked for the incoming op, valid only when ex_hit
    always_ff @(posedge CLK) begin
        if (div_load) begin
            dw_op       <= ex_op;
            dw_a        <= ex_a;
            dw_b        <= ex_b;
            dw_tag      <= ex_tag;
            dw_hit_data <= ex_op.div.is_rem ? remainder : quotient;
        end
    end

    div32_iterative divider0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .start     (div_start),
        .is_signed (~ex_op.div.is_unsigned),
        .a         (ex_a),
        .b         (ex_b),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign div_req   = dw_valid & (dw_hit | div_done);
    assign div_stall = dw_valid & ~div_grant;

    always_comb begin
        if (dw_hit) begin
            div_wb.data = dw_hit_data;
        end else begin
            div_wb.data = dw_op.div.is_rem ? remainder : quotient;
        end
        div_wb.tag = dw_tag;
    end

endmodule

`default_nettype wire

// ==== design/mdu_wb_arbiter.sv ====
// Round-robin writeback arbiter between the multiply and divide paths, drives the wb port
`timescale 1ns/1ps
`default_nettype none

module mdu_wb_arbiter
    import mdu_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  logic    mul_req,
    input  mdu_wb_t mul_wb,
    input  logic    div_req,
    input  mdu_wb_t div_wb,
    input  logic    wb_ready,
    output logic    mul_grant,
    output logic    div_grant,
    output logic    wb_valid,
    output mdu_wb_t wb
);

    // Priority, 0 means multiply first
    logic div_first;
    logic sel_div;

    assign wb_valid  = mul_req | div_req;
    assign sel_div   = div_req & (~mul_req | div_first);
    assign mul_grant = wb_ready & mul_req & ~sel_div;
    assign div_grant = wb_ready & sel_div;

    assign wb = sel_div ? div_wb : mul_wb;

    // Turn passes after a grant, pinned to the shown path while stalled
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            div_first <= 1'b0;
        end else if (wb_valid) begin
            div_first <= wb_ready ? ~sel_div : sel_div;
        end
    end

endmodule

`default_nettype wire

// ==== design/mdu_top.sv ====
// Top of the multiply-divide execute pipeline, connects EX, both result paths and writeback
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_top
    import mdu_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       issue_valid,
    input  mdu_issue_t issue,
    output logic       issue_ready,
    output logic       wb_valid,
    output mdu_wb_t    wb,
    input  logic       wb_ready
);

    // EX stage outputs
    logic                 ex_valid;
    mdu_op_u              ex_op;
    logic [`MDU_XLEN-1:0] ex_a;
    logic [`MDU_XLEN-1:0] ex_b;
    mdu_tag_t             ex_tag;
    logic                 ex_advance;
    logic                 ex_hit;

    // DIV_WB contents seen by the reuse compare
    logic                 dw_valid;
    mdu_op_u              dw_op;
    logic [`MDU_XLEN-1:0] dw_a;
    logic [`MDU_XLEN-1:0] dw_b;

    // Path handshakes with the arbiter
    logic    mul_stall;
    logic    div_stall;
    logic    mul_req;
    logic    div_req;
    logic    mul_grant;
    logic    div_grant;
    mdu_wb_t mul_wb;
    mdu_wb_t div_wb;

    mdu_ex_stage ex_stage0 (.*);

    mdu_mul_path mul_path0 (.*);

    mdu_div_path div_path0 (.*);

    mdu_wb_arbiter wb_arbiter0 (.*);

endmodule

`default_nettype wire

// ==== verification/mdu_tb.sv ====
// Testbench for the multiply-divide pipeline, applies a stimulus table and scores every writeback
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_tb
    import mdu_pkg::*;
();

    localparam int XLEN = `MDU_XLEN;

    localparam logic [2:0] OP_MUL    = 3'b000;
    localparam logic [2:0] OP_MULH   = 3'b001;
    localparam logic [2:0] OP_MULHSU = 3'b010;
    localparam logic [2:0] OP_MULHU  = 3'b011;
    localparam logic [2:0] OP_DIV    = 3'b100;
    localparam logic [2:0] OP_DIVU   = 3'b101;
    localparam logic [2:0] OP_REM    = 3'b110;
    localparam logic [2:0] OP_REMU   = 3'b111;

    // One table row with the expected word from the model
    typedef struct packed {
        mdu_op_u         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [1:0]      gap;
        logic [XLEN-1:0] exp;
    } row_t;

    logic       CLK;
    logic       nRST;
    logic       issue_valid;
    mdu_issue_t issue;
    logic       issue_ready;
    logic       wb_valid;
    mdu_wb_t    wb;
    logic       wb_ready;

    row_t        rows[$];
    int          mul_q[$];
    int          div_q[$];
    logic [31:0] lfsr_state = 32'h1c80;
    int          wb_count;
    bit          rows_built;
    logic        held_valid;
    mdu_wb_t     held_wb;

    mdu_top dut0 (.*);

    always #5 CLK = ~CLK;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input mdu_tag_t got, input mdu_tag_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int j = 0; j < n; j++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mdu_tag_t make_tag(input int idx);
        mdu_tag_t t;
        t.dest_pr   = `MDU_PR_BITS'(idx * 5 + 3);
        t.rob_index = `MDU_ROB_BITS'(idx);
        return t;
    endfunction

    // RISC-V M results with products taken mod 2^64 on extended operands
    function automatic logic [XLEN-1:0] model_result(input mdu_op_u op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] sa;
        logic [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0] ua;
        logic [2*XLEN-1:0] ub;
        logic [2*XLEN-1:0] p;
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        ua = {{XLEN{1'b0}}, a};
        ub = {{XLEN{1'b0}}, b};
        if (!op.mul.is_div) begin
            case (op.mul.mul_kind)
                2'd0:    p = sa * sb;
                2'd1:    p = sa * sb;
                2'd2:    p = sa * ub;
                default: p = ua * ub;
            endcase
            return (op.mul.mul_kind == 2'd0) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
        end
        if (b == '0) begin
            return op.div.is_rem ? a : '1;
        end
        if (op.div.is_unsigned) begin
            return op.div.is_rem ? a % b : a / b;
        end
        if (a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
            return op.div.is_rem ? '0 : a;
        end
        return op.div.is_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    endfunction

    task automatic add_row(input logic [2:0] op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [1:0] gap);
        row_t r;
        r.op.raw = op;
        r.a      = a;
        r.b      = b;
        r.gap    = gap;
        r.exp    = model_result(r.op, a, b);
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [2:0]      op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [1:0]      gap;
        // Multiplies on signed and unsigned extremes
        add_row(OP_MUL,    32'h7fffffff, 32'h7fffffff, 0);
        add_row(OP_MULH,   32'h80000000, 32'h80000000, 1);
        add_row(OP_MULH,   32'h80000000, 32'h7fffffff, 0);
        add_row(OP_MULHSU, 32'h80000000, 32'hffffffff, 0);
        add_row(OP_MULHSU, 32'hffffffff, 32'hffffffff, 2);
        add_row(OP_MULHU,  32'hffffffff, 32'hffffffff, 0);
        add_row(OP_MUL,    32'hffffffff, 32'h12345678, 0);
        // DIV then REM reuses the result while DIVU after DIV recomputes
        add_row(OP_DIV,    32'hffffff9c, 32'h00000007, 0);
        add_row(OP_REM,    32'hffffff9c, 32'h00000007, 0);
        add_row(OP_DIVU,   32'hffffff9c, 32'h00000007, 0);
        add_row(OP_REMU,   32'hffffff9c, 32'h00000007, 0);
        // Divide by zero and overflow
        add_row(OP_DIV,    32'h00001234, 32'h00000000, 1);
        add_row(OP_REM,    32'h00001234, 32'h00000000, 0);
        add_row(OP_DIVU,   32'h80000000, 32'h00000000, 0);
        add_row(OP_REMU,   32'h80000000, 32'h00000000, 0);
        add_row(OP_DIV,    32'h80000000, 32'hffffffff, 0);
        add_row(OP_REM,    32'h80000000, 32'hffffffff, 0);
        // Mixed traffic issued back to back
        add_row(OP_DIV,    32'h00000007, 32'hfffffffe, 3);
        add_row(OP_REM,    32'h00000007, 32'hfffffffe, 0);
        add_row(OP_DIVU,   32'hdeadbeef, 32'h00000010, 0);
        add_row(OP_MULHU,  32'hdeadbeef, 32'h00000010, 0);
        add_row(OP_MULH,   32'hfffffffe, 32'h00000003, 0);
        add_row(OP_REMU,   32'hdeadbeef, 32'h00000010, 0);
        add_row(OP_MUL,    32'h00000003, 32'h00000005, 0);
        for (int k = 0; k < 8; k++) begin
            op  = 3'(random_bits(3));
            a   = random_bits(XLEN);
            b   = (k == 3) ? '0 : random_bits(XLEN);
            gap = 2'(random_bits(2));
            add_row(op, a, b, gap);
        end
    endtask

    // ------------------------------------------------------------
    // One clock cycle from a falling edge after issue is driven
    // ------------------------------------------------------------

    task automatic run_cycle(output bit accepted);
        int idx;
        int exp_idx;
        wb_ready = 1'(random_bits(1));
        #1;
        // Stalled result must stay put
        if (held_valid && !wb_valid) begin
            fail_run("wb_valid dropped while its result waited for wb_ready");
        end else if (held_valid) begin
            check_data("wb.data", wb.data, held_wb.data);
            check_tag("wb.tag", wb.tag, held_wb.tag);
        end
        held_valid = wb_valid & ~wb_ready;
        held_wb    = wb;
        if (wb_valid && wb_ready) begin
            idx = int'(wb.tag.rob_index);
            if (idx >= rows.size()) begin
                fail_run("writeback carries a rob_index that was never issued");
            end else if (rows[idx].op.div.is_div ? div_q.size() == 0 : mul_q.size() == 0) begin
                fail_run("writeback arrived with no operation outstanding on its path");
            end else begin
                exp_idx = rows[idx].op.div.is_div ? div_q.pop_front() : mul_q.pop_front();
                check_tag("wb.tag", wb.tag, make_tag(exp_idx));
                check_data("wb.data", wb.data, rows[exp_idx].exp);
                wb_count++;
            end
        end
        accepted = issue_valid & issue_ready;
        if (accepted && issue.op.div.is_div) begin
            div_q.push_back(int'(issue.tag.rob_index));
        end else if (accepted) begin
            mul_q.push_back(int'(issue.tag.rob_index));
        end
        @(negedge CLK);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------

    initial begin
        bit accepted;
        CLK         = 1'b0;
        nRST        = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        wb_ready    = 1'b0;
        wb_count    = 0;
        held_valid  = 1'b0;
        build_table();
        rows_built = 1'b1;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        #1;
        if (wb_valid !== 1'b0) begin
            fail_run("wb_valid is high after reset with nothing issued");
        end else if (issue_ready !== 1'b1) begin
            fail_run("issue_ready is low after reset");
        end
        @(negedge CLK);
        for (int i = 0; i < rows.size(); i++) begin
            issue_valid = 1'b0;
            repeat (rows[i].gap) run_cycle(accepted);
            issue_valid = 1'b1;
            issue.op    = rows[i].op;
            issue.a     = rows[i].a;
            issue.b     = rows[i].b;
            issue.tag   = make_tag(i);
            accepted    = 1'b0;
            while (!accepted) run_cycle(accepted);
        end
        issue_valid = 1'b0;
        issue       = '0;
        while (wb_count < rows.size()) run_cycle(accepted);
        // Any further writeback would be a duplicate
        repeat (4) run_cycle(accepted);
        #1;
        if (wb_valid !== 1'b0) begin
            fail_run("wb_valid still high after every row was written back");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // Budget per row covers a full division plus stalls
    initial begin
        wait (rows_built);
        #(rows.size() * (`MDU_DIV_STEPS + 10) * 10);
        fail_run("watchdog expired before all results were written back");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
design/mdu_pkg.sv
design/div32_iterative.sv
design/mdu_ex_stage.sv
design/mdu_mul_path.sv
design/mdu_div_path.sv
design/mdu_wb_arbiter.sv
design/mdu_top.sv
verification/mdu_tb.sv
